/* logic/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define DATA_WIDTH 32
`define REG_COUNT  32
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

`define OP_RTYPE 6'b000000
`define OP_ADDI  6'b001000
`define OP_LW    6'b100011
`define OP_SW    6'b101011
`define OP_BEQ   6'b000100

`define FN_ADD 6'b100000
`define FN_SUB 6'b100010
`define FN_AND 6'b100100
`define FN_OR  6'b100101
`define FN_SLT 6'b101010

`define ALU_AND 4'b0000
`define ALU_OR  4'b0001
`define ALU_ADD 4'b0010
`define ALU_SUB 4'b0110
`define ALU_SLT 4'b0111

`endif

/* logic/decodeStage.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module decodeStage
    import mipsPkg::*;
(
    input  logic    CLK,
    input  logic    RST,
    input  instrT   ifInstr,
    input  wordT    ifPcPlus4,
    input  logic    wbValid,
    input  regAddrT wbReg,
    input  wordT    wbData,
    output logic    regWrite,
    output logic    memToReg,
    output logic    branch,
    output logic    memWrite,
    output logic    aluSrc,
    output logic    regDst,
    output aluOpT   aluOp,
    output wordT    idPcPlus4,
    output wordT    idRs,
    output wordT    idRt,
    output wordT    idImm,
    output regAddrT idRtNum,
    output regAddrT idRdNum
);

    opcodeT  opcode;
    regAddrT rsNum;
    regAddrT rtNum;
    regAddrT rdNum;
    wordT    immExt;
    wordT    rsVal;
    wordT    rtVal;

    logic  cRegWrite;
    logic  cMemToReg;
    logic  cBranch;
    logic  cMemWrite;
    logic  cAluSrc;
    logic  cRegDst;
    aluOpT cAluOp;

    wordT regFile [`REG_COUNT];

    assign opcode = ifInstr[31:26];
    assign rsNum  = ifInstr[25:21];
    assign rtNum  = ifInstr[20:16];
    assign rdNum  = ifInstr[15:11];
    assign immExt = {{16{ifInstr[15]}}, ifInstr[15:0]};

    //////////////////////////////////////////////////////////////////////
    // Control decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        cRegWrite = 1'b0;
        cMemToReg = 1'b0;
        cBranch   = 1'b0;
        cMemWrite = 1'b0;
        cAluSrc   = 1'b0;
        cRegDst   = 1'b0;
        cAluOp    = 2'b00;
        case (opcode)
            `OP_RTYPE: begin
                cRegWrite = 1'b1;
                cRegDst   = 1'b1;
                cAluOp    = 2'b10;
            end
            `OP_ADDI: begin
                cRegWrite = 1'b1;
                cAluSrc   = 1'b1;
            end
            `OP_LW: begin
                cRegWrite = 1'b1;
                cMemToReg = 1'b1;
                cAluSrc   = 1'b1;
            end
            `OP_SW: begin
                cMemWrite = 1'b1;
                cAluSrc   = 1'b1;
            end
            `OP_BEQ: begin
                cBranch = 1'b1;
                cAluOp  = 2'b01;                 // Compare by subtraction
            end
            default: ;                           // Treated as no-op
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
        end else if (wbValid) begin
            regFile[wbReg] <= wbData;
        end
    end

    // Write-through on same-cycle writeback
    assign rsVal = (rsNum == '0) ? '0 :
                   (wbValid && wbReg == rsNum) ? wbData : regFile[rsNum];
    assign rtVal = (rtNum == '0) ? '0 :
                   (wbValid && wbReg == rtNum) ? wbData : regFile[rtNum];

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            regWrite  <= 1'b0;
            memToReg  <= 1'b0;
            branch    <= 1'b0;
            memWrite  <= 1'b0;
            aluSrc    <= 1'b0;
            regDst    <= 1'b0;
            aluOp     <= '0;
            idPcPlus4 <= '0;
            idRs      <= '0;
            idRt      <= '0;
            idImm     <= '0;
            idRtNum   <= '0;
            idRdNum   <= '0;
        end else begin
            regWrite  <= cRegWrite;
            memToReg  <= cMemToReg;
            branch    <= cBranch;
            memWrite  <= cMemWrite;
            aluSrc    <= cAluSrc;
            regDst    <= cRegDst;
            aluOp     <= cAluOp;
            idPcPlus4 <= ifPcPlus4;
            idRs      <= rsVal;
            idRt      <= rtVal;
            idImm     <= immExt;
            idRtNum   <= rtNum;
            idRdNum   <= rdNum;
        end
    end

endmodule

/* logic/executeStage.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module executeStage
    import mipsPkg::*;
(
    input  logic    CLK,
    input  logic    RST,
    input  logic    regWrite,
    input  logic    memToReg,
    input  logic    branch,
    input  logic    memWrite,
    input  logic    aluSrc,
    input  logic    regDst,
    input  aluOpT   aluOp,
    input  wordT    idPcPlus4,
    input  wordT    idRs,
    input  wordT    idRt,
    input  wordT    idImm,
    input  regAddrT idRtNum,
    input  regAddrT idRdNum,
    output logic    exRegWrite,
    output logic    exMemToReg,
    output logic    exBranch,
    output logic    exMemWrite,
    output wordT    exBranchTarget,
    output wordT    exAluResult,
    output logic    exZero,
    output wordT    exStoreData,
    output regAddrT exDestReg
);

    functT   funct;
    aluCtrlT aluCtrl;
    wordT    operandB;
    wordT    aluResult;

    assign funct    = idImm[5:0];            // R-type function field
    assign operandB = aluSrc ? idImm : idRt;

    always_comb begin
        case (aluOp)
            2'b00:   aluCtrl = `ALU_ADD;     // addi, lw, sw
            2'b01:   aluCtrl = `ALU_SUB;     // beq
            default: begin
                case (funct)
                    `FN_SUB: aluCtrl = `ALU_SUB;
                    `FN_AND: aluCtrl = `ALU_AND;
                    `FN_OR:  aluCtrl = `ALU_OR;
                    `FN_SLT: aluCtrl = `ALU_SLT;
                    default: aluCtrl = `ALU_ADD;
                endcase
            end
        endcase
    end

    always_comb begin
        case (aluCtrl)
            `ALU_AND: aluResult = idRs & operandB;
            `ALU_OR:  aluResult = idRs | operandB;
            `ALU_SUB: aluResult = idRs - operandB;
            `ALU_SLT: aluResult = (idRs < operandB) ? 32'd1 : 32'd0;  // Unsigned
            default:  aluResult = idRs + operandB;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // EX/MEM register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            exRegWrite     <= 1'b0;
            exMemToReg     <= 1'b0;
            exBranch       <= 1'b0;
            exMemWrite     <= 1'b0;
            exBranchTarget <= '0;
            exAluResult    <= '0;
            exZero         <= 1'b0;
            exStoreData    <= '0;
            exDestReg      <= '0;
        end else begin
            exRegWrite     <= regWrite;
            exMemToReg     <= memToReg;
            exBranch       <= branch;
            exMemWrite     <= memWrite;
            exBranchTarget <= idPcPlus4 + {idImm[29:0], 2'b00};
            exAluResult    <= aluResult;
            exZero         <= (aluResult == '0);
            exStoreData    <= idRt;
            exDestReg      <= regDst ? idRdNum : idRtNum;
        end
    end

endmodule

/* logic/fetchStage.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module fetchStage
    import mipsPkg::*;
(
    input  logic     CLK,
    input  logic     RST,
    input  logic     run,
    input  logic     loadEn,
    input  imemAddrT loadAddr,
    input  instrT    loadData,
    input  logic     takeBranch,
    input  wordT     branchTarget,
    output instrT    ifInstr,
    output wordT     ifPcPlus4
);

    wordT     pc;
    wordT     pcPlus4;
    imemAddrT fetchIdx;
    instrT    fetchWord;

    instrT imem [`IMEM_DEPTH];

    assign pcPlus4   = pc + 32'd4;
    assign fetchIdx  = pc[7:2];
    assign fetchWord = imem[fetchIdx];

    //////////////////////////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;               // Held at start while stopped
        end else if (takeBranch) begin
            pc <= branchTarget;
        end else begin
            pc <= pcPlus4;
        end
    end

    // Program load port
    always_ff @(posedge CLK) begin
        if (loadEn) begin
            imem[loadAddr] <= loadData;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // IF/ID register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            ifInstr   <= '0;
            ifPcPlus4 <= '0;
        end else begin
            ifInstr   <= run ? fetchWord : '0;   // No-op while stopped
            ifPcPlus4 <= run ? pcPlus4 : '0;
        end
    end

endmodule

/* logic/memoryStage.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module memoryStage
    import mipsPkg::*;
(
    input  logic    CLK,
    input  logic    RST,
    input  logic    exRegWrite,
    input  logic    exMemToReg,
    input  logic    exBranch,
    input  logic    exMemWrite,
    input  wordT    exBranchTarget,
    input  wordT    exAluResult,
    input  logic    exZero,
    input  wordT    exStoreData,
    input  regAddrT exDestReg,
    output logic    takeBranch,
    output wordT    branchTarget,
    output logic    wbValid,
    output regAddrT wbReg,
    output wordT    wbData,
    output logic    storeValid,
    output wordT    storeAddr,
    output wordT    storeData
);

    dmemAddrT memIdx;
    wordT     loadWord;
    logic     wbMemToReg;
    wordT     wbAluResult;
    wordT     wbLoadWord;

    wordT dmem [`DMEM_DEPTH];

    assign memIdx   = exAluResult[7:2];
    assign loadWord = dmem[memIdx];

    assign takeBranch   = exBranch & exZero;
    assign branchTarget = exBranchTarget;

    assign storeValid = exMemWrite;
    assign storeAddr  = exAluResult;
    assign storeData  = exStoreData;

    //////////////////////////////////////////////////////////////////////
    // Data memory
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (exMemWrite) begin
            dmem[memIdx] <= exStoreData;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // MEM/WB register and writeback select
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            wbValid     <= 1'b0;
            wbReg       <= '0;
            wbMemToReg  <= 1'b0;
            wbAluResult <= '0;
            wbLoadWord  <= '0;
        end else begin
            wbValid     <= exRegWrite && (exDestReg != '0);   // r0 writes dropped
            wbReg       <= exDestReg;
            wbMemToReg  <= exMemToReg;
            wbAluResult <= exAluResult;
            wbLoadWord  <= loadWord;
        end
    end

    assign wbData = wbMemToReg ? wbLoadWord : wbAluResult;

endmodule

/* logic/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore
    import mipsPkg::*;
(
    input  logic     CLK,
    input  logic     RST,
    input  logic     run,
    input  logic     loadEn,
    input  imemAddrT loadAddr,
    input  instrT    loadData,
    output logic     wbValid,
    output regAddrT  wbReg,
    output wordT     wbData,
    output logic     storeValid,
    output wordT     storeAddr,
    output wordT     storeData
);

    instrT   ifInstr;
    wordT    ifPcPlus4;
    logic    regWrite, memToReg, branch, memWrite, aluSrc, regDst;
    aluOpT   aluOp;
    wordT    idPcPlus4, idRs, idRt, idImm;
    regAddrT idRtNum, idRdNum;
    logic    exRegWrite, exMemToReg, exBranch, exMemWrite, exZero;
    wordT    exBranchTarget, exAluResult, exStoreData;
    regAddrT exDestReg;
    logic    takeBranch;
    wordT    branchTarget;

    fetchStage i_fetchStage (
        .CLK, .RST, .run, .loadEn, .loadAddr, .loadData,
        .takeBranch, .branchTarget, .ifInstr, .ifPcPlus4
    );

    decodeStage i_decodeStage (
        .CLK, .RST, .ifInstr, .ifPcPlus4, .wbValid, .wbReg, .wbData,
        .regWrite, .memToReg, .branch, .memWrite, .aluSrc, .regDst, .aluOp,
        .idPcPlus4, .idRs, .idRt, .idImm, .idRtNum, .idRdNum
    );

    executeStage i_executeStage (
        .CLK, .RST,
        .regWrite, .memToReg, .branch, .memWrite, .aluSrc, .regDst, .aluOp,
        .idPcPlus4, .idRs, .idRt, .idImm, .idRtNum, .idRdNum,
        .exRegWrite, .exMemToReg, .exBranch, .exMemWrite, .exBranchTarget,
        .exAluResult, .exZero, .exStoreData, .exDestReg
    );

    memoryStage i_memoryStage (
        .CLK, .RST,
        .exRegWrite, .exMemToReg, .exBranch, .exMemWrite, .exBranchTarget,
        .exAluResult, .exZero, .exStoreData, .exDestReg,
        .takeBranch, .branchTarget,
        .wbValid, .wbReg, .wbData,
        .storeValid, .storeAddr, .storeData
    );

endmodule

/* logic/mipsPkg.sv */
`include "core_defs.svh"

package mipsPkg;

    //////////////////////////////////////////////////////////////////////
    // Datapath vectors
    //////////////////////////////////////////////////////////////////////

    typedef logic [`DATA_WIDTH-1:0] wordT;      // Data, PC and byte address
    typedef logic [`DATA_WIDTH-1:0] instrT;

    typedef logic [$clog2(`REG_COUNT)-1:0]  regAddrT;
    typedef logic [$clog2(`IMEM_DEPTH)-1:0] imemAddrT;  // Word index
    typedef logic [$clog2(`DMEM_DEPTH)-1:0] dmemAddrT;  // Word index

    //////////////////////////////////////////////////////////////////////
    // Instruction fields and control
    //////////////////////////////////////////////////////////////////////

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    // 00 add, 01 sub, 10 from function code
    typedef logic [1:0] aluOpT;

    typedef logic [3:0] aluCtrlT;

endpackage

/* mipsCore.f */
+incdir+logic
logic/mipsPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/mipsCore.sv
verif/tbClockGen.sv
verif/mipsCore_props.sv
verif/mipsCoreTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the mipsCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f mipsCore.f --top-module mipsCoreTb -o simMipsCore > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simMipsCore > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    echo "Simulation log has no pass line"
    exit 1
fi
exit 0

/* verif/mipsCoreTb.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module mipsCoreTb
    import mipsPkg::*;
();

    logic     CLK, RST, run, loadEn;
    imemAddrT loadAddr;
    instrT    loadData;
    logic     wbValid, storeValid;
    regAddrT  wbReg;
    wordT     wbData, storeAddr, storeData;

    logic [31:0] lfsr = 32'd81761;
    instrT       prog [64];
    int          progLen;
    wordT        mReg [32] = '{default: '0};   // Architectural model state
    wordT        mMem [64] = '{default: '0};
    regAddrT     expWbReg [$];
    wordT        expWbData [$];
    wordT        expStAddr [$];
    wordT        expStData [$];
    functT       fnList [8] = '{`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT,
                                `FN_ADD, `FN_SUB, `FN_SLT};

    tbClockGen i_clockGen (.CLK(CLK));
    mipsCore i_mipsCore (.*);

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        lsb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb) lfsr = lfsr ^ 32'h80200003;
            r = {r[30:0], lsb};
        end
        return r;
    endfunction

    function automatic instrT rType(functT fn, regAddrT rs, regAddrT rt, regAddrT rd);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic instrT iType(opcodeT op, regAddrT rs, regAddrT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Sequential instruction-set model
    //////////////////////////////////////////////////////////////////////

    function automatic void runModel();
        int      pc;
        instrT   ins;
        wordT    a, b, imm, res, addr;
        regAddrT dst;
        logic    wr;
        pc = 0;
        while (pc < progLen) begin
            ins = prog[imemAddrT'(pc)];
            a   = mReg[ins[25:21]];
            b   = mReg[ins[20:16]];
            imm = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm;
            dst = ins[20:16];
            res = '0;
            wr  = 1'b0;
            pc++;
            case (ins[31:26])
                `OP_RTYPE: begin
                    wr  = 1'b1;
                    dst = ins[15:11];
                    case (ins[5:0])
                        `FN_SUB: res = a - b;
                        `FN_AND: res = a & b;
                        `FN_OR:  res = a | b;
                        `FN_SLT: res = (a < b) ? 32'd1 : 32'd0;   // Unsigned compare
                        default: res = a + b;
                    endcase
                end
                `OP_ADDI: begin
                    wr  = 1'b1;
                    res = addr;
                end
                `OP_LW: begin
                    wr  = 1'b1;
                    res = mMem[addr[7:2]];
                end
                `OP_SW: begin
                    expStAddr.push_back(addr);
                    expStData.push_back(b);
                    mMem[addr[7:2]] = b;
                end
                `OP_BEQ: if (a == b) pc = pc + $signed(imm);  // Word-granular target
                default: ;
            endcase
            if (wr && dst != '0) begin
                mReg[dst] = res;
                expWbReg.push_back(dst);
                expWbData.push_back(res);
            end
        end
    endfunction

    task automatic failNow(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped at first failure");
    endtask

    task automatic checkWord(wordT got, wordT exp, string what);
        if (got !== exp) begin
            failNow($sformatf("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkReg(regAddrT got, regAddrT exp, string what);
        if (got !== exp) begin
            failNow($sformatf("ERROR %0t ns: %s is r%0d, expected r%0d", $time, what, got, exp));
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge CLK) begin
        if (wbValid) begin
            if (expWbReg.size() == 0) failNow("A register writeback came that was not expected");
            checkReg(wbReg, expWbReg.pop_front(), "writeback register");
            checkWord(wbData, expWbData.pop_front(), "writeback data");
        end
        if (storeValid) begin
            if (expStAddr.size() == 0) failNow("A store came that was not expected");
            checkWord(storeAddr, expStAddr.pop_front(), "store address");
            checkWord(storeData, expStData.pop_front(), "store data");
        end
    end

    task automatic tick();
        @(posedge CLK);
        #1;
    endtask

    task automatic clearProg();
        for (int i = 0; i < 64; i++) prog[imemAddrT'(i)] = '0;
        progLen = 0;
    endtask

    // Three zero no-ops follow each instruction
    task automatic emit(instrT ins);
        prog[imemAddrT'(progLen)] = ins;
        progLen += 4;
    endtask

    task automatic runProgram(string name);
        int cycles;
        runModel();
        for (int i = 0; i < 64; i++) begin
            loadEn   = 1'b1;
            loadAddr = imemAddrT'(i);
            loadData = prog[imemAddrT'(i)];
            tick();
        end
        loadEn = 1'b0;
        run    = 1'b1;
        cycles = 0;
        while (cycles < progLen + 1 || expWbReg.size() != 0 || expStAddr.size() != 0) begin
            if (cycles >= 60) failNow({"Timed out waiting for the events of the ", name, " program"});
            tick();
            cycles++;
        end
        run = 1'b0;
        for (int d = 0; d < 6; d++) tick();   // Drain in-flight no-ops
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [15:0] off [3];
        logic [15:0] brVal;
        RST      = 1'b1;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        for (int i = 0; i < 5; i++) tick();
        RST = 1'b0;
        for (int i = 0; i < 10; i++) tick();   // Stopped core stays silent

        clearProg();
        emit(iType(`OP_ADDI, 5'd0, 5'd1, 16'd5));
        emit(iType(`OP_ADDI, 5'd0, 5'd2, 16'd5));
        emit(iType(`OP_SW, 5'd0, 5'd1, 16'd8));
        emit(iType(`OP_ADDI, 5'd1, 5'd3, 16'hFFFD));
        emit(iType(`OP_BEQ, 5'd1, 5'd2, 16'd7));   // Taken branch skips the sub
        emit(rType(`FN_SUB, 5'd1, 5'd3, 5'd4));
        emit(iType(`OP_BEQ, 5'd1, 5'd3, 16'd7));
        emit(rType(`FN_ADD, 5'd1, 5'd3, 5'd5));
        emit(iType(`OP_LW, 5'd0, 5'd6, 16'd8));
        runProgram("directed");

        clearProg();
        for (int i = 0; i < 12; i++) begin
            if (randBits(1) != 0) begin
                emit(iType(`OP_ADDI, regAddrT'(randBits(3)), regAddrT'(randBits(3)),
                           16'(randBits(16))));
            end else begin
                emit(rType(fnList[3'(randBits(3))], regAddrT'(randBits(3)),
                           regAddrT'(randBits(3)), regAddrT'(randBits(3))));
            end
        end
        runProgram("random ALU");

        clearProg();
        for (int i = 0; i < 3; i++) begin
            emit(iType(`OP_ADDI, 5'd0, regAddrT'(16 + i), 16'(randBits(16))));
        end
        for (int i = 0; i < 3; i++) begin
            off[i] = 16'(randBits(6) << 2);
            emit(iType(`OP_SW, 5'd0, regAddrT'(16 + i), off[i]));
        end
        for (int i = 0; i < 3; i++) emit(iType(`OP_LW, 5'd0, regAddrT'(20 + i), off[i]));
        runProgram("memory");

        clearProg();
        for (int i = 0; i < 3; i++) begin
            brVal = 16'(randBits(1));
            emit(iType(`OP_ADDI, 5'd0, 5'd8, brVal));
            if (i == 0) begin
                emit(iType(`OP_ADDI, 5'd0, 5'd9, brVal));           // Taken
            end else if (i == 1) begin
                emit(iType(`OP_ADDI, 5'd0, 5'd9, brVal ^ 16'd1));   // Not taken
            end else begin
                emit(iType(`OP_ADDI, 5'd0, 5'd9, 16'(randBits(1))));
            end
            emit(iType(`OP_BEQ, 5'd8, 5'd9, 16'd7));
            emit(iType(`OP_ADDI, 5'd10, 5'd10, 16'd1));
        end
        runProgram("branch");

        clearProg();
        emit(iType(`OP_ADDI, 5'd0, 5'd0, 16'd77));    // Discarded write
        emit(iType(`OP_ADDI, 5'd0, 5'd13, 16'd9));
        emit(rType(`FN_ADD, 5'd0, 5'd13, 5'd14));
        emit(iType(`OP_SW, 5'd0, 5'd0, 16'd12));
        runProgram("register 0");

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* verif/mipsCore_props.sv */
`timescale 1ns/1ps

module mipsCoreProps
    import mipsPkg::*;
(
    input logic    CLK,
    input logic    RST,
    input logic    run,
    input logic    loadEn,
    input logic    wbValid,
    input regAddrT wbReg,
    input logic    storeValid
);

    quietInReset: assert property (@(posedge CLK) RST |-> (!wbValid && !storeValid))
        else $error("Writeback or store event while reset is asserted");

    wbRegNonzero: assert property (@(posedge CLK) disable iff (RST) wbValid |-> wbReg != '0)
        else $error("Writeback reported for register 0");

    // Program load only while the core is stopped
    loadWhileStopped: assert property (@(posedge CLK) disable iff (RST) !(loadEn && run))
        else $error("Instruction memory written while the core runs");

endmodule

bind mipsCore mipsCoreProps i_mipsCoreProps (
    .CLK(CLK), .RST(RST), .run(run), .loadEn(loadEn),
    .wbValid(wbValid), .wbReg(wbReg), .storeValid(storeValid)
);

/* verif/tbClockGen.sv */
`timescale 1ns/1ps

module tbClockGen (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;   // 8 ns period
    end

endmodule
